/* adc_frontend/adc_frontend.sv */
// ADC input side, registers the pin words, decodes them and muxes in the DAC loopback
`timescale 1ns/1ps
`include "analog_settings.svh"

module adc_frontend
  import analog_pkg::*;
(
  input  logic                    adc_clk,         // sample clock
  input  logic                    top_rst,         // async, active high
  input  pin_code_u [`CH_N-1:0]   adc_pin_i,       // raw pin codes
  input  sample_vec_t             dac_sat_i,       // saturated DAC samples
  input  logic                    digital_loop_i,  // static loopback level
  output sample_vec_t             acq_dat_o        // acquired samples
);

////////////////////////////////////////
// pin registers
////////////////////////////////////////

// upper 14 bits of the converter only, low reserved bits never reach the port
pin_code_u [`CH_N-1:0] pin_q;  // one word per channel

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    for (int ch = 0; ch < `CH_N; ch++) begin
      pin_q[ch].raw <= '0;  // code zero, decodes to +max
    end
  end else begin
    for (int ch = 0; ch < `CH_N; ch++) begin
      pin_q[ch].raw <= adc_pin_i[ch].raw;
    end
  end
end

////////////////////////////////////////
// decode and loopback mux
////////////////////////////////////////

generate
  for (genvar i = 0; i < `CH_N; i++) begin : g_adc_ch

    sample_t adc_dec;  // two's complement view of the pin word

    // negative slope: keep sign, flip body
    assign adc_dec = {pin_q[i].fld.sign_bit, ~pin_q[i].fld.body};

    // loopback bypasses the pin register entirely
    // same channel only, no crossing
    assign acq_dat_o[i] = digital_loop_i ? dac_sat_i[i] : adc_dec;

  end : g_adc_ch
endgenerate

endmodule

/* common/analog_pkg.sv */
// sample, sum and converter pin word types, import with analog_pkg::* in the module header
`include "analog_settings.svh"

package analog_pkg;

  ////////////////////////////////////////
  // datapath samples
  ////////////////////////////////////////

  // two's complement sample, same width on ADC and DAC side
  typedef logic signed [`SAMPLE_W-1:0] sample_t;

  // mixer sum before saturation
  typedef logic signed [`SUM_W-1:0] sum_t;

  // one sample per channel
  typedef sample_t [`CH_N-1:0] sample_vec_t;

  ////////////////////////////////////////
  // converter pin word
  ////////////////////////////////////////

  // negative-slope offset coding on the pins
  // same word read flat or split into sign and body
  typedef union packed {
    logic [`SAMPLE_W-1:0] raw;  // flat pin code
    struct packed {
      logic                 sign_bit;  // kept as is
      logic [`SAMPLE_W-2:0] body;      // inverted on conversion
    } fld;
  } pin_code_u;

endpackage

/* common/analog_settings.svh */
// channel count and sample widths for the analog core, include wherever a width is needed
`ifndef ANALOG_SETTINGS_SVH
`define ANALOG_SETTINGS_SVH

////////////////////////////////////////
// channels
////////////////////////////////////////

`define CH_N 2  // fixed by the port layout

////////////////////////////////////////
// sample widths
////////////////////////////////////////

`define SAMPLE_W 14              // ADC and DAC sample
`define SUM_W (`SAMPLE_W + 1)    // mixer sum, one guard bit

// low pin bits of a 16-bit converter part
// not routed, the 14-bit word sits in the upper bits
`define ADC_RSV_W 2

`endif

/* dac_path/dac_backend.sv */
// DAC output side, recodes saturated samples to pin codes and registers them with the DAC reset
`timescale 1ns/1ps
`include "analog_settings.svh"

module dac_backend
  import analog_pkg::*;
(
  input  logic                    adc_clk,    // sample clock
  input  logic                    top_rst,    // async, active high
  input  sample_vec_t             dac_sat_i,  // saturated samples from the mixer
  output pin_code_u [`CH_N-1:0]   dac_dat_o,  // registered pin codes
  output logic                    dac_rst_o   // DAC reset level
);

////////////////////////////////////////
// recode to negative-slope offset
////////////////////////////////////////

pin_code_u [`CH_N-1:0] dac_code;  // next pin word per channel

always_comb begin
  for (int ch = 0; ch < `CH_N; ch++) begin
    dac_code[ch].fld.sign_bit = dac_sat_i[ch][`SAMPLE_W-1];   // sign unchanged
    dac_code[ch].fld.body     = ~dac_sat_i[ch][`SAMPLE_W-2:0];  // body flipped
  end
end

////////////////////////////////////////
// output registers
////////////////////////////////////////

always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    for (int ch = 0; ch < `CH_N; ch++) begin
      dac_dat_o[ch].raw <= {1'b0, {(`SAMPLE_W-1){1'b1}}};  // zero sample, 8191
    end
  end else begin
    dac_dat_o <= dac_code;
  end
end

// held high in reset, drops on the first edge after release
always_ff @(posedge adc_clk, posedge top_rst) begin
  if (top_rst) begin
    dac_rst_o <= 1'b1;
  end else begin
    dac_rst_o <= 1'b0;
  end
end

endmodule

/* dac_path/dac_mixer.sv */
// per-channel DAC mixer, adds generator and controller samples and saturates to sample width
`timescale 1ns/1ps
`include "analog_settings.svh"

module dac_mixer
  import analog_pkg::*;
(
  input  sample_vec_t gen_dat_i,   // generator samples
  input  sample_vec_t ctrl_dat_i,  // controller samples
  output sample_vec_t dac_sat_o    // saturated sum per channel
);

////////////////////////////////////////
// add and saturate
////////////////////////////////////////

// purely combinational, feeds both the DAC register and the loopback mux
generate
  for (genvar i = 0; i < `CH_N; i++) begin : g_mix_ch

    sum_t    dac_sum;  // one guard bit above sample width
    logic    sum_ovf;  // top two sum bits disagree
    sample_t sat_lim;  // limit picked by sum sign

    // both operands signed, so the casts sign extend
    assign dac_sum = sum_t'(gen_dat_i[i]) + sum_t'(ctrl_dat_i[i]);

    assign sum_ovf = dac_sum[`SUM_W-1] ^ dac_sum[`SUM_W-2];

    // negative sum -> 100..0, positive sum -> 011..1
    assign sat_lim = {dac_sum[`SUM_W-1], {(`SAMPLE_W-1){~dac_sum[`SUM_W-1]}}};

    // in range: drop the guard bit
    assign dac_sat_o[i] = sum_ovf ? sat_lim : dac_sum[`SAMPLE_W-1:0];

  end : g_mix_ch
endgenerate

// range check
//   +8191 + 1      = 15'h2000 -> ovf, clamps to +8191
//   -8192 + (-1)   = 15'h5fff -> ovf, clamps to -8192
//   +8191 + -8192  = -1, passes through

endmodule

/* filelist.f */
+incdir+common
common/analog_pkg.sv
adc_frontend/adc_frontend.sv
dac_path/dac_mixer.sv
dac_path/dac_backend.sv
verilog/analog_top.sv
sim/tb_clock_gen.sv
sim/tb_analog_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the analog core testbench with Verilator and runs it from the project root
# the run counts as passed only if the pass line shows up in the output

cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module tb_analog_top -o sim_analog_top &&
./obj_dir/sim_analog_top | tee /dev/stderr | grep -qx "PASS: all tests" &&
echo "run_sim: simulation passed" ||
{
  echo "run_sim: simulation failed"
  exit 1
}

/* sim/analog_patterns.txt */
# name loop pin0 pin1 gen0 gen1 ctrl0 ctrl1 adc_exp0 adc_exp1 dac_exp0 dac_exp1
# decimal, samples signed, pin and dac columns raw 14-bit codes, adc of a line before loop=1 unseen
# adc decoding, loopback low
dec_zero     0     0 16383     0     0     0     0  8191 -8192  8191  8191
dec_mid      0  8192  8191     0     0     0     0    -1     0  8191  8191
dec_bit0     0     1     2     0     0     0     0  8190  8189  8191  8191
dec_low      0     4     8     0     0     0     0  8187  8183  8191  8191
dec_bits     0  4096  2048     0     0     0     0  4095  6143  8191  8191
dec_top      0 12288 16382     0     0     0     0 -4097 -8191  8191  8191
dec_mix      0  1234 15000     0     0     0     0  6957 -6809  8191  8191
# mixer inside the 14-bit range
mix_small    0   100   200    10   -20     5    30  8091  7991  8176  8181
mix_neg      0   300   400 -1000  2000  -500 -3000  7891  7791  9691  9191
mix_cancel   0   500   600  8191 -8192 -8192  8000  7691  7591  8192  8383
mix_edge_pos 0   700   800  4095  4000  4096  4191  7491  7391     0     0
mix_edge_neg 0   900  1000 -4096 -5000 -4096 -3192  7291  7191 16383 16383
# saturation
sat_pos1     0  1100  1200  4096  8191  4096     1  7091  6991     0     0
sat_neg1     0  1300  1400 -4096 -8192 -4097    -1  6891  6791 16383 16383
sat_pos_max  0  1500  1600  8191  8191  8191   100  6691  6591     0     0
sat_neg_max  0  1700  1800 -8192 -8192 -8192 -5000  6491  6391 16383 16383
sat_mixed    0  1900  2000  6000 -6000  3000 -3000  6291  6191     0 16383
# loopback, pins ignored
loop_basic   1 16383     0   123  -456    77    56   200  -400  7991  8591
loop_sat     1  8192  8191  8000 -8000   500  -500  8191 -8192     0 16383
loop_swap    1     5     6    -3     3    -4     4    -7     7  8198  8184
loop_big     1 10000    20  2500 -7000  2500  1000  5000 -6000  3191 14191
# back-to-back streaming
strm_a       0  3000 13000     1     2     3     4  5191 -4809  8187  8185
strm_b       0  3001 13001    -1    -2    -3    -4  5190 -4810  8195  8197
strm_c       0     0 16383  8191 -8192  8191 -8192  8191 -8192     0 16383
strm_d       0 16383     0     0     0     0     0 -8192  8191  8191  8191
strm_e       0  6000  7000  2047 -2048  2048 -2047  2191  1191  4096 12286
strm_f       0  8191  8192   100   200   -50  -250     0    -1  8141  8241

/* sim/tb_analog_top.sv */
// testbench top for the analog core that replays sim/analog_patterns.txt and checks every output
`timescale 1ns/1ps
`include "analog_settings.svh"

module tb_analog_top
  import analog_pkg::*;
();

////////////////////////////////////////
// constants and signals
////////////////////////////////////////

localparam int MAX_VEC      = 64;    // vector storage
localparam int MIN_VEC      = 20;    // fewer means a truncated file
localparam int RST_TIMEOUT  = 40;    // cycles to wait for reset release
localparam int DRV_DLY      = 1;     // ns after the rising edge
localparam int SMP_DLY      = 2;     // sampling point in the reset loop in ns
localparam int ZERO_CODE    = 8191;  // pin code of sample zero
localparam int RST_PIN_CODE = 5461;  // pin code held on the inputs during reset
localparam int RST_GEN_VAL  = 1000;  // generator sample held during reset

logic                  adc_clk;
logic                  top_rst;
pin_code_u [`CH_N-1:0] adc_pin_i;
sample_vec_t           gen_dat_i;
sample_vec_t           ctrl_dat_i;
logic                  digital_loop_i;
sample_vec_t           adc_dat_o;
pin_code_u [`CH_N-1:0] dac_dat_o;
logic                  dac_rst_o;

// one entry per pattern line
reg [8*24-1:0] name_v [MAX_VEC];
int loop_v [MAX_VEC];
int pin_v [MAX_VEC][`CH_N];
int gen_v [MAX_VEC][`CH_N];
int ctrl_v [MAX_VEC][`CH_N];
int adc_exp_v [MAX_VEC][`CH_N];  // checked in the cycle the result shows
int dac_exp_v [MAX_VEC][`CH_N];  // checked one edge after the drive

int n_vec   = 0;
int err_cnt = 0;
int chk_cnt = 0;
bit run_ok;

////////////////////////////////////////
// clock, reset and DUT
////////////////////////////////////////

tb_clock_gen u_clock_gen (
  .adc_clk (adc_clk),
  .top_rst (top_rst)
);

analog_top UUT (
  .adc_clk        (adc_clk       ),
  .top_rst        (top_rst       ),
  .adc_pin_i      (adc_pin_i     ),
  .gen_dat_i      (gen_dat_i     ),
  .ctrl_dat_i     (ctrl_dat_i    ),
  .digital_loop_i (digital_loop_i),
  .adc_dat_o      (adc_dat_o     ),
  .dac_dat_o      (dac_dat_o     ),
  .dac_rst_o      (dac_rst_o     )
);

////////////////////////////////////////
// checking
////////////////////////////////////////

task automatic check_val(input string test_name, input string sig_name,
                         input int exp_v, input int act_v);
  chk_cnt++;
  if (exp_v !== act_v) begin
    err_cnt++;
    $display("ERR %0s %0s: expected %0d, actual %0d", test_name, sig_name, exp_v, act_v);
  end
endtask

task automatic check_adc(input int i);
  for (int ch = 0; ch < `CH_N; ch++) begin
    check_val($sformatf("%0s", name_v[i]), $sformatf("adc_dat_o[%0d]", ch),
              adc_exp_v[i][ch], int'(adc_dat_o[ch]));  // signed element so the cast sign extends
  end
endtask

task automatic check_dac(input int i);
  for (int ch = 0; ch < `CH_N; ch++) begin
    check_val($sformatf("%0s", name_v[i]), $sformatf("dac_dat_o[%0d]", ch),
              dac_exp_v[i][ch], int'(dac_dat_o[ch].raw));
  end
endtask

////////////////////////////////////////
// pattern file
////////////////////////////////////////

task automatic load_patterns(output bit ok);
  int            fd;
  int            rc;
  int            line_no;
  string         line;
  reg [8*24-1:0] nm;
  int            lp;
  int            p0, p1, g0, g1, c0, c1, a0, a1, d0, d1;
  ok      = 1'b0;
  line_no = 0;
  fd = $fopen("sim/analog_patterns.txt", "r");
  if (fd == 0) begin
    $display("cannot open the pattern file sim/analog_patterns.txt");
  end else begin
    while (!$feof(fd) && n_vec < MAX_VEC) begin
      rc = $fgets(line, fd);
      line_no++;
      // skip comments and blank lines
      if (rc != 0 && line.len() > 1 && line[0] != "#") begin
        rc = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d",
                     nm, lp, p0, p1, g0, g1, c0, c1, a0, a1, d0, d1);
        if (rc == 12) begin
          name_v[n_vec]       = nm;
          loop_v[n_vec]       = lp;
          pin_v[n_vec][0]     = p0;
          pin_v[n_vec][1]     = p1;
          gen_v[n_vec][0]     = g0;
          gen_v[n_vec][1]     = g1;
          ctrl_v[n_vec][0]    = c0;
          ctrl_v[n_vec][1]    = c1;
          adc_exp_v[n_vec][0] = a0;
          adc_exp_v[n_vec][1] = a1;
          dac_exp_v[n_vec][0] = d0;
          dac_exp_v[n_vec][1] = d1;
          n_vec++;
        end else begin
          err_cnt++;
          $display("pattern file line %0d does not hold 12 fields", line_no);
        end
      end
    end
    $fclose(fd);
    if (n_vec < MIN_VEC) begin
      $display("pattern file holds only %0d vectors, at least %0d needed", n_vec, MIN_VEC);
    end else begin
      ok = 1'b1;
    end
  end
endtask

////////////////////////////////////////
// stimulus
////////////////////////////////////////

task automatic drive_vec(input int i);
  digital_loop_i = (loop_v[i] != 0);
  for (int ch = 0; ch < `CH_N; ch++) begin
    adc_pin_i[ch].raw = sample_t'(pin_v[i][ch]);  // same width as the pin word
    gen_dat_i[ch]     = sample_t'(gen_v[i][ch]);
    ctrl_dat_i[ch]    = sample_t'(ctrl_v[i][ch]);
  end
endtask

task automatic drive_idle();
  digital_loop_i = 1'b0;  // lets the last pin result through
  adc_pin_i      = '0;
  gen_dat_i      = '0;
  ctrl_dat_i     = '0;
endtask

// checks the reset values and waits for release with a timeout
task automatic wait_reset(output bit ok);
  int cyc;
  ok  = 1'b0;
  cyc = 0;
  while (!ok && cyc < RST_TIMEOUT) begin
    @(posedge adc_clk);
    #SMP_DLY;
    cyc++;
    if (cyc == 3) begin
      check_val("reset", "dac_rst_o", 1, int'(dac_rst_o));
      for (int ch = 0; ch < `CH_N; ch++) begin
        check_val("reset", $sformatf("dac_dat_o[%0d]", ch), ZERO_CODE, int'(dac_dat_o[ch].raw));
        check_val("reset", $sformatf("adc_dat_o[%0d]", ch), 8191, int'(adc_dat_o[ch]));
      end
    end
    if (top_rst === 1'b0) ok = 1'b1;
  end
  if (!ok) begin
    $display("timeout: top_rst still high after %0d cycles", RST_TIMEOUT);
  end else begin
    check_val("reset_release", "dac_rst_o", 1, int'(dac_rst_o));  // no edge yet
    @(posedge adc_clk);
    #DRV_DLY;
    check_val("reset_release", "dac_rst_o", 0, int'(dac_rst_o));
  end
endtask

// one line per cycle plus one idle cycle to flush the last results
task automatic run_vectors();
  bit loop_now;
  for (int i = 0; i <= n_vec; i++) begin
    @(posedge adc_clk);
    #DRV_DLY;
    if (i < n_vec) begin
      drive_vec(i);
    end else begin
      drive_idle();
    end
    loop_now = (i < n_vec) ? (loop_v[i] != 0) : 1'b0;
    @(negedge adc_clk);  // mid cycle where everything has settled
    if (loop_now) check_adc(i);  // loopback shows in the same cycle
    // pin path shows one edge later unless loopback hides it now
    if (i > 0 && loop_v[i-1] == 0 && !loop_now) check_adc(i - 1);
    if (i > 0) check_dac(i - 1);
  end
endtask

////////////////////////////////////////
// main sequence
////////////////////////////////////////

initial begin
  // inputs away from zero during reset so only the clear gives the reset values
  adc_pin_i      = {`CH_N{sample_t'(RST_PIN_CODE)}};
  gen_dat_i      = {`CH_N{sample_t'(RST_GEN_VAL)}};
  ctrl_dat_i     = '0;
  digital_loop_i = 1'b0;
  load_patterns(run_ok);
  if (run_ok) wait_reset(run_ok);
  if (run_ok) run_vectors();
  $display("tb_analog_top: %0d vectors, %0d checks, %0d errors", n_vec, chk_cnt, err_cnt);
  if (run_ok && err_cnt == 0) begin
    $display("PASS: all tests");
  end else begin
    $display("FAIL: see errors above");
  end
  $finish;
end

endmodule

/* sim/tb_clock_gen.sv */
// testbench clock and reset source, drives adc_clk at 8 ns and holds top_rst for 8 cycles
`timescale 1ns/1ps

module tb_clock_gen (
  output logic adc_clk,  // 125 MHz sample clock
  output logic top_rst   // active high, released off the edge
);

localparam int HALF_PER = 4;  // ns
localparam int RST_CYC  = 8;  // cycles in reset
localparam int REL_DLY  = 1;  // ns after the edge

initial begin
  adc_clk = 1'b0;
  forever #HALF_PER adc_clk = ~adc_clk;
end

initial begin
  top_rst = 1'b1;
  repeat (RST_CYC) @(posedge adc_clk);
  #REL_DLY top_rst = 1'b0;
end

endmodule

/* verilog/analog_top.sv */
// analog core top, connects the ADC input side, the DAC mixer and the DAC output side
`timescale 1ns/1ps
`include "analog_settings.svh"

module analog_top
  import analog_pkg::*;
(
  input  logic                    adc_clk,         // single core clock
  input  logic                    top_rst,         // async, active high
  // ADC
  input  pin_code_u [`CH_N-1:0]   adc_pin_i,       // raw ADC pin codes
  // sample sources
  input  sample_vec_t             gen_dat_i,       // generator samples
  input  sample_vec_t             ctrl_dat_i,      // controller samples
  // configuration
  input  logic                    digital_loop_i,  // loopback enable, static
  // outputs
  output sample_vec_t             adc_dat_o,       // acquired samples
  output pin_code_u [`CH_N-1:0]   dac_dat_o,       // DAC pin codes
  output logic                    dac_rst_o        // DAC reset level
);

////////////////////////////////////////
// internal buses
////////////////////////////////////////

sample_vec_t acq_dat;  // acquired, after the loopback mux
sample_vec_t dac_sat;  // mixer result, to DAC and back to loopback

////////////////////////////////////////
// ADC input side
////////////////////////////////////////

adc_frontend u_adc_frontend (
  .adc_clk        (adc_clk       ),
  .top_rst        (top_rst       ),
  .adc_pin_i      (adc_pin_i     ),
  .dac_sat_i      (dac_sat       ),  // loopback source
  .digital_loop_i (digital_loop_i),
  .acq_dat_o      (acq_dat       )
);

assign adc_dat_o = acq_dat;

////////////////////////////////////////
// DAC mixer
////////////////////////////////////////

dac_mixer u_dac_mixer (
  .gen_dat_i  (gen_dat_i ),
  .ctrl_dat_i (ctrl_dat_i),
  .dac_sat_o  (dac_sat   )   // comb, 0 cycles
);

////////////////////////////////////////
// DAC output side
////////////////////////////////////////

dac_backend u_dac_backend (
  .adc_clk   (adc_clk  ),
  .top_rst   (top_rst  ),
  .dac_sat_i (dac_sat  ),
  .dac_dat_o (dac_dat_o),  // 1 cycle after the mixer
  .dac_rst_o (dac_rst_o)
);

endmodule
